/* verilog/core_pkg.sv */
// shared widths, opcode and operation enums
// decode to execute pipeline struct
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // fetch address after reset
  localparam word_t reset_pc = 32'h0000_0000;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jump
  } branch_e;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     operand1;
    word_t     operand2;
    word_t     store_data;
    word_t     imm;
    alu_op_e   alu_op;
    branch_e   branch;
    logic      jalr;
    logic      load;
    logic      store;
    logic      reg_wen;
    reg_addr_t reg_waddr;
  } id_ex_t;

endpackage

/* verilog/core_reg.sv */
// integer register file, x0 reads as zero
// combinational reads with write-through bypass
module core_reg (
  input  logic               clk,
  input  logic               arst_n,
  input  core_pkg::reg_addr_t reg1_raddr,
  input  core_pkg::reg_addr_t reg2_raddr,
  output core_pkg::word_t    reg1_rdata,
  output core_pkg::word_t    reg2_rdata,
  input  logic               reg_wen,
  input  core_pkg::reg_addr_t reg_waddr,
  input  core_pkg::word_t    reg_wdata
);
  import core_pkg::*;

  word_t regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wen && reg_waddr != '0) begin
      regs[reg_waddr] <= reg_wdata;
    end
  end

  // write in the same cycle wins over the stored value
  assign reg1_rdata = (reg1_raddr == '0) ? '0 :
                      (reg_wen && reg_waddr == reg1_raddr) ? reg_wdata : regs[reg1_raddr];
  assign reg2_rdata = (reg2_raddr == '0) ? '0 :
                      (reg_wen && reg_waddr == reg2_raddr) ? reg_wdata : regs[reg2_raddr];

endmodule

/* verilog/instruction_fetch.sv */
// program counter and next address selection
// fetch/decode pipeline register
module instruction_fetch (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            stall_n,
  input  logic            flush,
  input  core_pkg::word_t jump_addr,
  output core_pkg::word_t instruction_addr,
  input  core_pkg::word_t instruction,
  output core_pkg::word_t instruction_if_id,
  output core_pkg::word_t pc_if_id,
  output logic            valid_if_id
);
  import core_pkg::*;

  word_t pc;

  assign instruction_addr = pc;

  // flush only arrives while not stalled
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= reset_pc;
    end else if (flush) begin
      pc <= jump_addr;
    end else if (stall_n) begin
      pc <= pc + 32'd4;
    end
  end

  // the word being fetched while a jump resolves is dropped
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_if_id <= 1'b0;
    end else if (flush) begin
      valid_if_id <= 1'b0;
    end else if (stall_n) begin
      valid_if_id <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (stall_n) begin
      instruction_if_id <= instruction;
      pc_if_id          <= pc;
    end
  end

endmodule

/* verilog/instruction_decode.sv */
// instruction decode and immediate generation
// operand selection and decode/execute register
module instruction_decode (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                stall_n,
  input  logic                flush,
  input  core_pkg::word_t     instruction_if_id,
  input  core_pkg::word_t     pc_if_id,
  input  logic                valid_if_id,
  output core_pkg::reg_addr_t reg1_raddr,
  output core_pkg::reg_addr_t reg2_raddr,
  input  core_pkg::word_t     reg1_rdata,
  input  core_pkg::word_t     reg2_rdata,
  output core_pkg::id_ex_t    id_ex
);
  import core_pkg::*;

  opcode_e opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  logic legal;
  id_ex_t id_ex_d;

  // funct3 to alu operation, alt picks sub or sra
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode = opcode_e'(instruction_if_id[6:0]);
  assign funct3 = instruction_if_id[14:12];
  assign funct7 = instruction_if_id[31:25];
  assign reg1_raddr = instruction_if_id[19:15];
  assign reg2_raddr = instruction_if_id[24:20];

  assign imm_i = {{20{instruction_if_id[31]}}, instruction_if_id[31:20]};
  assign imm_s = {{20{instruction_if_id[31]}}, instruction_if_id[31:25], instruction_if_id[11:7]};
  assign imm_b = {{19{instruction_if_id[31]}}, instruction_if_id[31], instruction_if_id[7],
                  instruction_if_id[30:25], instruction_if_id[11:8], 1'b0};
  assign imm_u = {instruction_if_id[31:12], 12'h000};
  assign imm_j = {{11{instruction_if_id[31]}}, instruction_if_id[31], instruction_if_id[19:12],
                  instruction_if_id[20], instruction_if_id[30:21], 1'b0};

  always_comb begin
    id_ex_d = '0;
    id_ex_d.pc = pc_if_id;
    id_ex_d.operand1 = reg1_rdata;
    id_ex_d.operand2 = reg2_rdata;
    id_ex_d.store_data = reg2_rdata;
    id_ex_d.reg_waddr = instruction_if_id[11:7];
    id_ex_d.alu_op = alu_add;
    id_ex_d.branch = br_none;
    legal = 1'b1;
    case (opcode)
      opc_op: begin
        legal = (funct7 == 7'b0000000) ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        id_ex_d.alu_op = alu_sel(funct3, funct7[5]);
        id_ex_d.reg_wen = 1'b1;
      end
      opc_op_imm: begin
        // shift immediates carry funct7 in the upper bits
        if (funct3 == 3'b001) legal = (funct7 == 7'b0000000);
        if (funct3 == 3'b101) legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        id_ex_d.alu_op = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
        id_ex_d.operand2 = imm_i;
        id_ex_d.reg_wen = 1'b1;
      end
      opc_lui: begin
        id_ex_d.alu_op = alu_pass_b;
        id_ex_d.operand2 = imm_u;
        id_ex_d.reg_wen = 1'b1;
      end
      opc_auipc: begin
        id_ex_d.operand1 = pc_if_id;
        id_ex_d.operand2 = imm_u;
        id_ex_d.reg_wen = 1'b1;
      end
      opc_jal: begin
        id_ex_d.operand1 = pc_if_id;
        id_ex_d.operand2 = imm_j;
        id_ex_d.imm = imm_j;
        id_ex_d.branch = br_jump;
        id_ex_d.reg_wen = 1'b1;
      end
      opc_jalr: begin
        legal = (funct3 == 3'b000);
        id_ex_d.operand2 = imm_i;
        id_ex_d.imm = imm_i;
        id_ex_d.branch = br_jump;
        id_ex_d.jalr = 1'b1;
        id_ex_d.reg_wen = 1'b1;
      end
      opc_branch: begin
        id_ex_d.imm = imm_b;
        case (funct3)
          3'b000:  id_ex_d.branch = br_eq;
          3'b001:  id_ex_d.branch = br_ne;
          3'b100:  id_ex_d.branch = br_lt;
          3'b101:  id_ex_d.branch = br_ge;
          3'b110:  id_ex_d.branch = br_ltu;
          3'b111:  id_ex_d.branch = br_geu;
          default: legal = 1'b0;
        endcase
      end
      opc_load: begin
        // word access only
        legal = (funct3 == 3'b010);
        id_ex_d.operand2 = imm_i;
        id_ex_d.load = 1'b1;
        id_ex_d.reg_wen = 1'b1;
      end
      opc_store: begin
        legal = (funct3 == 3'b010);
        id_ex_d.operand2 = imm_s;
        id_ex_d.store = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    id_ex_d.valid = valid_if_id & legal;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex <= '0;
    end else if (flush) begin
      id_ex <= '0;
    end else if (stall_n) begin
      id_ex <= id_ex_d;
    end
  end

endmodule

/* verilog/instruction_execute.sv */
// alu, branch and jump resolution
// load/store access and register write-back
module instruction_execute (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                stall_n,
  input  core_pkg::id_ex_t    id_ex,
  output logic                reg_wen,
  output core_pkg::reg_addr_t reg_waddr,
  output core_pkg::word_t     reg_wdata,
  output logic                jump,
  output core_pkg::word_t     jump_addr,
  output logic                ram_read,
  output core_pkg::word_t     ram_raddr,
  input  core_pkg::word_t     ram_rdata,
  output logic                ram_write,
  output logic [1:0]          ram_write_width,
  output core_pkg::word_t     ram_waddr,
  output core_pkg::word_t     ram_wdata
);
  import core_pkg::*;

  // store width code for a full word
  localparam logic [1:0] width_word = 2'd2;

  word_t op1;
  word_t op2;
  word_t sum;
  word_t alu_result;
  word_t link;
  logic taken;
  logic jump_sent;

  assign op1 = id_ex.operand1;
  assign op2 = id_ex.operand2;
  assign sum = op1 + op2;
  assign link = id_ex.pc + 32'd4;

  always_comb begin
    case (id_ex.alu_op)
      alu_add:    alu_result = sum;
      alu_sub:    alu_result = op1 - op2;
      alu_sll:    alu_result = op1 << op2[4:0];
      alu_slt:    alu_result = {31'b0, $signed(op1) < $signed(op2)};
      alu_sltu:   alu_result = {31'b0, op1 < op2};
      alu_xor:    alu_result = op1 ^ op2;
      alu_srl:    alu_result = op1 >> op2[4:0];
      alu_sra:    alu_result = word_t'($signed(op1) >>> op2[4:0]);
      alu_or:     alu_result = op1 | op2;
      alu_and:    alu_result = op1 & op2;
      alu_pass_b: alu_result = op2;
      default:    alu_result = sum;
    endcase
  end

  // branches compare rs1 against rs2
  always_comb begin
    case (id_ex.branch)
      br_eq:   taken = (op1 == op2);
      br_ne:   taken = (op1 != op2);
      br_lt:   taken = ($signed(op1) < $signed(op2));
      br_ge:   taken = ($signed(op1) >= $signed(op2));
      br_ltu:  taken = (op1 < op2);
      br_geu:  taken = (op1 >= op2);
      br_jump: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign jump_addr = id_ex.jalr ? {sum[31:1], 1'b0} : id_ex.pc + id_ex.imm;

  // a jump seen during a stall is reported once, the controller keeps it pending
  assign jump = id_ex.valid & taken & ~jump_sent;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      jump_sent <= 1'b0;
    end else if (stall_n) begin
      jump_sent <= 1'b0;
    end else if (jump) begin
      jump_sent <= 1'b1;
    end
  end

  assign reg_wen = id_ex.valid & id_ex.reg_wen & stall_n;
  assign reg_waddr = id_ex.reg_waddr;
  assign reg_wdata = (id_ex.branch == br_jump) ? link :
                     id_ex.load ? ram_rdata : alu_result;

  assign ram_read = id_ex.valid & id_ex.load & stall_n;
  assign ram_raddr = sum;
  assign ram_write = id_ex.valid & id_ex.store & stall_n;
  assign ram_write_width = width_word;
  assign ram_waddr = sum;
  assign ram_wdata = id_ex.store_data;

endmodule

/* verilog/core_ctrl.sv */
// stall request merge and flush generation
module core_ctrl #(
  parameter int stall_req_num = 1
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [stall_req_num-1:0] stall_req,
  input  logic                     jump,
  output logic                     stall_n,
  output logic                     flush
);

  logic jump_pending;

  assign stall_n = ~|stall_req;

  // jump waits for the stall to end, then flushes once
  assign flush = stall_n & (jump | jump_pending);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      jump_pending <= 1'b0;
    end else if (stall_n) begin
      jump_pending <= 1'b0;
    end else if (jump) begin
      jump_pending <= 1'b1;
    end
  end

endmodule

/* verilog/risc_v_core.sv */
// three-stage rv32i core top level
// fetch, decode, execute, register file and controller
module risc_v_core #(
  parameter int stall_req_num = 1
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [stall_req_num-1:0] stall_req,
  output logic                     core_stall_n,
  // instruction memory
  output core_pkg::word_t          instruction_addr,
  input  core_pkg::word_t          instruction,
  // data memory
  output logic                     ram_read,
  output logic                     ram_write,
  output logic [1:0]               ram_write_width,
  output core_pkg::word_t          ram_raddr,
  output core_pkg::word_t          ram_waddr,
  output core_pkg::word_t          ram_wdata,
  input  core_pkg::word_t          ram_rdata
);
  import core_pkg::*;

  logic stall_n;
  logic flush;
  logic jump;
  word_t jump_addr;

  reg_addr_t reg1_raddr;
  reg_addr_t reg2_raddr;
  word_t reg1_rdata;
  word_t reg2_rdata;
  logic reg_wen;
  reg_addr_t reg_waddr;
  word_t reg_wdata;

  word_t instruction_if_id;
  word_t pc_if_id;
  logic valid_if_id;
  id_ex_t id_ex;

  assign core_stall_n = stall_n;

  core_reg u_core_reg (
    .clk(clk), .arst_n(arst_n),
    .reg1_raddr(reg1_raddr), .reg2_raddr(reg2_raddr),
    .reg1_rdata(reg1_rdata), .reg2_rdata(reg2_rdata),
    .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata)
  );

  instruction_fetch u_instruction_fetch (
    .clk(clk), .arst_n(arst_n), .stall_n(stall_n), .flush(flush),
    .jump_addr(jump_addr),
    .instruction_addr(instruction_addr), .instruction(instruction),
    .instruction_if_id(instruction_if_id), .pc_if_id(pc_if_id), .valid_if_id(valid_if_id)
  );

  instruction_decode u_instruction_decode (
    .clk(clk), .arst_n(arst_n), .stall_n(stall_n), .flush(flush),
    .instruction_if_id(instruction_if_id), .pc_if_id(pc_if_id), .valid_if_id(valid_if_id),
    .reg1_raddr(reg1_raddr), .reg2_raddr(reg2_raddr),
    .reg1_rdata(reg1_rdata), .reg2_rdata(reg2_rdata),
    .id_ex(id_ex)
  );

  // memory access and write-back both happen here
  instruction_execute u_instruction_execute (
    .clk(clk), .arst_n(arst_n), .stall_n(stall_n), .id_ex(id_ex),
    .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
    .jump(jump), .jump_addr(jump_addr),
    .ram_read(ram_read), .ram_raddr(ram_raddr), .ram_rdata(ram_rdata),
    .ram_write(ram_write), .ram_write_width(ram_write_width),
    .ram_waddr(ram_waddr), .ram_wdata(ram_wdata)
  );

  core_ctrl #(.stall_req_num(stall_req_num)) u_core_ctrl (
    .clk(clk), .arst_n(arst_n), .stall_req(stall_req), .jump(jump),
    .stall_n(stall_n), .flush(flush)
  );

endmodule

/* bench/core_tb_mem.sv */
// instruction rom and data ram models for the core testbench
// store monitor keeps every ram write in order
module core_tb_mem (
  input  logic        clk,
  input  logic        mem_clear,
  input  logic        prog_we,
  input  logic [7:0]  prog_addr,
  input  logic [31:0] prog_data,
  input  logic [31:0] instruction_addr,
  output logic [31:0] instruction,
  input  logic        ram_read,
  input  logic        ram_write,
  input  logic [31:0] ram_raddr,
  input  logic [31:0] ram_waddr,
  input  logic [31:0] ram_wdata,
  output logic [31:0] ram_rdata,
  output logic [5:0]  store_count,
  output logic [31:0] log_addr [0:63],
  output logic [31:0] log_data [0:63]
);

  logic [31:0] rom [0:255];
  logic [31:0] ram [0:255];

  // both memories answer in the same cycle
  assign instruction = rom[instruction_addr[9:2]];
  // poison word unless the read strobe is up
  assign ram_rdata = ram_read ? ram[ram_raddr[9:2]] : 32'hdead_beef;

  always @(posedge clk) begin
    if (mem_clear) begin
      for (int i = 0; i < 256; i++) begin
        rom[i] <= '0;
        ram[i] <= '0;
      end
      store_count <= '0;
    end else begin
      if (prog_we) begin
        rom[prog_addr] <= prog_data;
      end
      if (ram_write) begin
        ram[ram_waddr[9:2]] <= ram_wdata;
        // last slot is kept free so the count cannot wrap
        if (store_count != 6'd63) begin
          log_addr[store_count] <= ram_waddr;
          log_data[store_count] <= ram_wdata;
          store_count <= store_count + 6'd1;
        end
      end
    end
  end

endmodule

/* bench/core_tb.sv */
// testbench for the three-stage rv32i core
// programs and expected stores come from the tests file
module core_tb;

  logic        clk;
  logic        arst_n;
  logic [0:0]  stall_req = 1'b0;
  logic        core_stall_n;
  logic [31:0] instruction_addr;
  logic [31:0] instruction;
  logic        ram_read;
  logic        ram_write;
  logic [1:0]  ram_write_width;
  logic [31:0] ram_raddr;
  logic [31:0] ram_waddr;
  logic [31:0] ram_wdata;
  logic [31:0] ram_rdata;
  logic        mem_clear;
  logic        prog_we;
  logic [7:0]  prog_addr;
  logic [31:0] prog_data;
  logic [5:0]  store_count;
  logic [31:0] log_addr [0:63];
  logic [31:0] log_data [0:63];
  logic [31:0] tests_mem [0:1023];

  int unsigned density;
  logic        stall_en;
  int          cycles = 0;
  int          cycle_limit = 0;
  int          port_errs = 0;
  int          port_errs_start;
  int          pass_count;
  int          fail_count;
  int          num_tests;
  int          p;
  int          n_words;
  int          n_dens;
  int          n_stores;
  int          bad;

  risc_v_core #(.stall_req_num(1)) dut_i (
    .clk(clk), .arst_n(arst_n), .stall_req(stall_req), .core_stall_n(core_stall_n),
    .instruction_addr(instruction_addr), .instruction(instruction),
    .ram_read(ram_read), .ram_write(ram_write), .ram_write_width(ram_write_width),
    .ram_raddr(ram_raddr), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata),
    .ram_rdata(ram_rdata)
  );

  core_tb_mem mem_i (
    .clk(clk), .mem_clear(mem_clear), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .instruction_addr(instruction_addr), .instruction(instruction),
    .ram_read(ram_read), .ram_write(ram_write),
    .ram_raddr(ram_raddr), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata),
    .ram_rdata(ram_rdata), .store_count(store_count), .log_addr(log_addr),
    .log_data(log_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // random stall request each cycle while a program runs
  always @(posedge clk) begin
    stall_req <= stall_en && (($urandom % 100) < density);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  // stall status follows the request, stores are always full words
  always @(posedge clk) begin
    if (core_stall_n !== !stall_req[0]) begin
      $display("ERROR %0t: core_stall_n %b with stall request %b", $time, core_stall_n,
               stall_req);
      port_errs = port_errs + 1;
    end
    if (ram_write === 1'b1 && ram_write_width !== 2'd2) begin
      $display("ERROR %0t: store to %h has width code %0d, 2 expected", $time, ram_waddr,
               ram_write_width);
      port_errs = port_errs + 1;
    end
  end

  // clear memories, load the program, then release reset after 4 cycles
  task automatic load_and_reset(input int base, input int words);
    @(posedge clk);
    arst_n <= 1'b0;
    stall_en <= 1'b0;
    mem_clear <= 1'b1;
    @(posedge clk);
    mem_clear <= 1'b0;
    for (int k = 0; k < words; k++) begin
      prog_we <= 1'b1;
      prog_addr <= k[7:0];
      prog_data <= tests_mem[base + k];
      @(posedge clk);
    end
    prog_we <= 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  // program ends with a store to the marker word
  task automatic wait_marker();
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = (store_count != 0) && (log_addr[store_count - 6'd1] == 32'h0000_03fc);
    end
  endtask

  task automatic check_stores(input int test_idx, input int base, input int count,
                              output int errs);
    int seen_n;
    errs = 0;
    seen_n = int'(store_count) - 1;
    if (seen_n != count) begin
      $display("ERROR %0t: test %0d has %0d stores before the marker, %0d expected",
               $time, test_idx, seen_n, count);
      errs++;
    end
    for (int k = 0; k < count && k < seen_n; k++) begin
      if (log_addr[k] != tests_mem[base + 2 * k] ||
          log_data[k] != tests_mem[base + 2 * k + 1]) begin
        $display("ERROR %0t: test %0d store %0d expected %h <= %h, seen %h <= %h",
                 $time, test_idx, k, tests_mem[base + 2 * k],
                 tests_mem[base + 2 * k + 1], log_addr[k], log_data[k]);
        errs++;
      end
    end
  endtask

  initial begin
    void'($urandom(32'h32ca2a73));
    arst_n = 1'b0;
    stall_en = 1'b0;
    density = 0;
    mem_clear = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    pass_count = 0;
    fail_count = 0;
    $readmemh("bench/core_tests.txt", tests_mem);
    num_tests = tests_mem[0];

    // 60 cycles per word, stretched by the stall density, plus load and reset
    p = 1;
    for (int t = 0; t < num_tests; t++) begin
      n_words = tests_mem[p];
      n_dens = tests_mem[p + 1];
      n_stores = tests_mem[p + 2];
      cycle_limit += 60 * n_words * 100 / (100 - n_dens) + n_words + 16;
      p += 3 + n_words + 2 * n_stores;
    end

    p = 1;
    for (int t = 1; t <= num_tests; t++) begin
      n_words = tests_mem[p];
      n_dens = tests_mem[p + 1];
      n_stores = tests_mem[p + 2];
      port_errs_start = port_errs;
      load_and_reset(p + 3, n_words);
      density <= n_dens;
      stall_en <= 1'b1;
      wait_marker();
      check_stores(t, p + 3 + n_words, n_stores, bad);
      bad += port_errs - port_errs_start;
      if (bad == 0) begin
        pass_count++;
      end else begin
        fail_count++;
      end
      $display("test %0d: %0d words, %0d%% stalls, %0d stores, %s", t, n_words, n_dens,
               n_stores, (bad == 0) ? "ok" : "mismatch");
      p += 3 + n_words + 2 * n_stores;
    end

    $display("%0d tests ok, %0d tests failing", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/core_pkg.sv
verilog/core_reg.sv
verilog/instruction_fetch.sv
verilog/instruction_decode.sv
verilog/instruction_execute.sv
verilog/core_ctrl.sv
verilog/risc_v_core.sv
bench/core_tb_mem.sv
bench/core_tb.sv

/* run.sh */
#!/bin/bash
# build the core testbench with Verilator, run it and scan the log

verilator --binary --timing -f verilog.f --top-module core_tb -o core_tb_sim \
  > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/core_tb_sim > sim.log 2>&1 || echo "simulation exited with an error status"
cat sim.log

grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log && exit 0 || exit 1

/* bench/core_tests.txt */
// first word: number of tests; each test: words, stall percent, store count (hex)
// then the program words, then expected store pairs: address data
00000006
// alu register and immediate forms, lui, auipc
00000021 00000000 0000000e
ffb00093 00300113 002081b3 40208233 002112b3 0020a333 0020b3b3 4010d413
01c0d493 0f00c513 123455b7 6785e613 0ff67693 00001717 ffc0a793 fff13813
4020d8b3 00302623 00402823 00502a23 00602c23 00702e23 02802023 02902223
02a02423 02c02823 02d02a23 02e02c23 02f02e23 05002023 05102223 3e002e23
0000006f
0000000c fffffffe 00000010 fffffff8 00000014 00000018 00000018 00000001
0000001c 00000000 00000020 fffffffd 00000024 0000000f 00000028 ffffff0b
00000030 12345678 00000034 00000078 00000038 00001034 0000003c 00000001
00000040 00000001 00000044 ffffffff
// six branches taken and not taken, 20 percent stalls
0000001e 00000014 00000006
ffb00093 00300113 7ad00493 0aa00513
00208463 00a02023 00108463 00902223 00209463 00902423 00211463 00a02623
0020c463 00902823 00114463 00a02a23 00115463 00902c23 0020d463 00a02e23
00116463 02902023 0020e463 02a02223 0020f463 02902423 00117463 02a02623
3e002e23 0000006f
00000000 000000aa 0000000c 000000aa 00000014 000000aa 0000001c 000000aa
00000024 000000aa 0000002c 000000aa
// jal and jalr links and targets, odd jalr target
00000011 00000000 00000003
7ad00493 00c000ef 00902023 00902223 00102423 02500113 000101e7 00902623
00902823 00302a23 01518267 00902c23 00402e23 0080006f 02902023 3e002e23
0000006f
00000008 00000008 00000014 0000001c 0000001c 0000002c
// store then load, writes to x0
0000000c 00000000 00000004
12300093 04102023 04002103 00110193 00500013 00318033 00300233 04302223
04402423 04002623 3e002e23 0000006f
00000040 00000123 00000044 00000124 00000048 00000124 0000004c 00000000
// dependent chain and loop without stalls
0000000f 00000000 00000005
00100093 001080b3 001080b3 00409113 401101b3 04302823 05002203 fff20213
04402a23 00300293 fff28293 04502c23 fe029ce3 3e002e23 0000006f
00000050 0000003c 00000054 0000003b 00000058 00000002 00000058 00000001
00000058 00000000
// same chain under 40 percent stalls
0000000f 00000028 00000005
00100093 001080b3 001080b3 00409113 401101b3 04302823 05002203 fff20213
04402a23 00300293 fff28293 04502c23 fe029ce3 3e002e23 0000006f
00000050 0000003c 00000054 0000003b 00000058 00000002 00000058 00000001
00000058 00000000
